// File: vlog.f
rtl/axil_reg_pkg.sv
rtl/axi_lite_if.sv
rtl/axil_write_capture.sv
rtl/axil_register_bank.sv
rtl/axil_read_mux.sv
rtl/axil_register_cu.sv
rtl/axil_register_top.sv
dv/axil_register_tb.sv

// File: Makefile
# Verilator build and run for the AXI4-Lite register block
# Any variable below can be overridden on the command line

VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
FILELIST        ?= vlog.f
TOP             ?= axil_register_tb
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR VERILATOR_FLAGS FILELIST TOP BUILD_DIR LOG"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif grep -q "Testbench passed" $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/axil_register_tb.sv
////////////////////////////////////////
// Register block testbench
// Clock, reset and DUT instance
// AXI-Lite master tasks with skew
// Register model, check task, watchdog
// Directed and random test sequence
////////////////////////////////////////
`default_nettype none

module axil_register_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import axil_reg_pkg::*;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 16;
    // Edges from the last AW or W handshake to bvalid, idle then write_exec
    localparam int b_latency = 2;
    // Edges from the AR handshake to rvalid, read_exec only
    localparam int r_latency = 1;
    localparam int n_rand_writes = 30;
    localparam int n_in_rounds   = 2;
    localparam int n_unmapped    = 8;
    localparam int n_txn = 3 + 2 * n_rand_writes + 6 * n_in_rounds + 2 * n_unmapped + 6;
    localparam int timeout_cycles = 50 * n_txn + reset_cycles;
    // Address regions
    localparam int ctrl_reg = 0;
    localparam int stat_reg = 1;
    localparam int no_reg   = 2;

    logic        clock;
    logic        rst_n;
    addr_t       awaddr;
    logic [2:0]  awprot;
    logic        awvalid;
    logic        awready;
    data_t       wdata;
    strb_t       wstrb;
    logic        wvalid;
    logic        wready;
    resp_t       bresp;
    logic        bvalid;
    logic        bready;
    addr_t       araddr;
    logic [2:0]  arprot;
    logic        arvalid;
    logic        arready;
    data_t       rdata;
    resp_t       rresp;
    logic        rvalid;
    logic        rready;
    read_bank_t  in_regs;
    write_bank_t out_regs;

    write_bank_t model;
    integer      seed = 98445;
    int          edge_count = 0;

    axil_register_top axil_register_top_inst (
        .clock    (clock),
        .rst_n    (rst_n),
        .awaddr   (awaddr),
        .awprot   (awprot),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arprot   (arprot),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .in_regs  (in_regs),
        .out_regs (out_regs)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    // Rising edge counter, read only on falling edges
    always @(posedge clock)
        edge_count <= edge_count + 1;

    // Watchdog sized from the transaction count
    initial begin
        repeat (timeout_cycles) @(posedge clock);
        $display("Timeout: test sequence still running after %0d clock cycles",
                 timeout_cycles);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check(input string what, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Byte lane merge under the write strobes
    function automatic data_t merge(input data_t old, input data_t wd, input strb_t strb);
        data_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                res[8*b +: 8] = wd[8*b +: 8];
        end
        return res;
    endfunction

    // Word offsets 0..2 control, 3..5 status, rest of the window unmapped
    function automatic int region(input addr_t addr);
        int word;
        word = int'(addr[window_bits-1:2]);
        if (addr[31:window_bits] != base_address[31:window_bits])
            return no_reg;
        if (word < n_write_regs)
            return ctrl_reg;
        if (word < n_write_regs + n_read_regs)
            return stat_reg;
        return no_reg;
    endfunction

    function automatic int word_index(input addr_t addr);
        return int'(addr[window_bits-1:2]);
    endfunction

    task automatic compare_bank();
        for (int i = 0; i < n_write_regs; i++)
            check("out_regs word", out_regs[i], model[i]);
    endtask

    // Valid raised after skew, dropped after the transfer edge
    task automatic drive_aw(input addr_t addr, input int skew, output int hs_edge);
        repeat (skew) @(negedge clock);
        awaddr  = addr;
        awvalid = 1'b1;
        while (!awready) @(negedge clock);
        hs_edge = edge_count + 1;
        @(negedge clock);
        awvalid = 1'b0;
    endtask

    task automatic drive_w(input data_t data, input strb_t strb, input int skew,
                           output int hs_edge);
        repeat (skew) @(negedge clock);
        wdata  = data;
        wstrb  = strb;
        wvalid = 1'b1;
        while (!wready) @(negedge clock);
        hs_edge = edge_count + 1;
        @(negedge clock);
        wvalid = 1'b0;
    endtask

    task automatic write_txn(input addr_t addr, input data_t data, input strb_t strb,
                             input int aw_skew, input int w_skew, input int b_wait);
        int    aw_edge;
        int    w_edge;
        int    last_edge;
        int    word;
        resp_t exp_resp;
        resp_t held_resp;
        awprot = 3'(rand_below(8));
        fork
            drive_aw(addr, aw_skew, aw_edge);
            drive_w(data, strb, w_skew, w_edge);
        join
        last_edge = (aw_edge > w_edge) ? aw_edge : w_edge;
        word = word_index(addr);
        // Model update and expected response
        if (region(addr) == ctrl_reg) begin
            model[word] = merge(model[word], data, strb);
            exp_resp = resp_okay;
        end else if (region(addr) == stat_reg) begin
            exp_resp = resp_slverr;
        end else begin
            exp_resp = resp_decerr;
        end
        while (!bvalid) @(negedge clock);
        check("write latency", data_t'(edge_count - last_edge), data_t'(b_latency));
        check("bresp", data_t'(bresp), data_t'(exp_resp));
        // New value visible together with bvalid
        compare_bank();
        held_resp = bresp;
        repeat (b_wait) begin
            @(negedge clock);
            check("bvalid under back-pressure", data_t'(bvalid), 32'd1);
            check("bresp under back-pressure", data_t'(bresp), data_t'(held_resp));
        end
        bready = 1'b1;
        @(negedge clock);
        bready = 1'b0;
        check("bvalid after B handshake", data_t'(bvalid), 32'd0);
    endtask

    task automatic read_txn(input addr_t addr, input int ar_skew, input int r_wait);
        int    ar_edge;
        int    word;
        data_t exp_data;
        resp_t exp_resp;
        data_t held_data;
        resp_t held_resp;
        word = word_index(addr);
        exp_data = '0;
        exp_resp = resp_decerr;
        if (region(addr) == ctrl_reg) begin
            exp_data = model[word];
            exp_resp = resp_okay;
        end else if (region(addr) == stat_reg) begin
            exp_data = in_regs[word - n_write_regs];
            exp_resp = resp_okay;
        end
        arprot = 3'(rand_below(8));
        repeat (ar_skew) @(negedge clock);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge clock);
        ar_edge = edge_count + 1;
        @(negedge clock);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clock);
        check("read latency", data_t'(edge_count - ar_edge), data_t'(r_latency));
        check("rdata", rdata, exp_data);
        check("rresp", data_t'(rresp), data_t'(exp_resp));
        held_data = rdata;
        held_resp = rresp;
        repeat (r_wait) begin
            @(negedge clock);
            check("rvalid under back-pressure", data_t'(rvalid), 32'd1);
            check("rdata under back-pressure", rdata, held_data);
            check("rresp under back-pressure", data_t'(rresp), data_t'(held_resp));
        end
        rready = 1'b1;
        @(negedge clock);
        rready = 1'b0;
        check("rvalid after R handshake", data_t'(rvalid), 32'd0);
    endtask

    // Random data, strobes, skews and waits
    task automatic write_random(input addr_t addr);
        data_t data;
        strb_t strb;
        int    aw_skew;
        int    w_skew;
        int    b_wait;
        data    = data_t'($random(seed));
        strb    = strb_t'(rand_below(16));
        aw_skew = int'(rand_below(4));
        w_skew  = int'(rand_below(4));
        b_wait  = int'(rand_below(4));
        write_txn(addr, data, strb, aw_skew, w_skew, b_wait);
    endtask

    task automatic read_random(input addr_t addr);
        int ar_skew;
        int r_wait;
        ar_skew = int'(rand_below(4));
        r_wait  = int'(rand_below(4));
        read_txn(addr, ar_skew, r_wait);
    endtask

    function automatic addr_t reg_addr(input int word);
        return base_address + addr_t'(4 * word);
    endfunction

    initial begin
        addr_t addr;
        rst_n   = 1'b0;
        awaddr  = '0;
        awprot  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arprot  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        model   = '0;
        for (int j = 0; j < n_read_regs; j++)
            in_regs[j] = data_t'($random(seed));

        // Quiet bus while in reset
        repeat (reset_cycles / 2) @(negedge clock);
        check("awready in reset", data_t'(awready), 32'd0);
        check("wready in reset", data_t'(wready), 32'd0);
        check("arready in reset", data_t'(arready), 32'd0);
        check("bvalid in reset", data_t'(bvalid), 32'd0);
        check("rvalid in reset", data_t'(rvalid), 32'd0);
        repeat (reset_cycles - reset_cycles / 2) @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);
        check("awready after reset", data_t'(awready), 32'd1);
        check("wready after reset", data_t'(wready), 32'd1);
        check("arready after reset", data_t'(arready), 32'd1);
        check("bvalid after reset", data_t'(bvalid), 32'd0);
        check("rvalid after reset", data_t'(rvalid), 32'd0);
        compare_bank();

        // Control registers read zero out of reset
        for (int i = 0; i < n_write_regs; i++)
            read_txn(reg_addr(i), 0, 0);

        // Random writes with read-back
        for (int n = 0; n < n_rand_writes; n++) begin
            addr = reg_addr(int'(rand_below(n_write_regs)));
            write_random(addr);
            read_random(addr);
        end

        // AW first, W first, both together
        write_txn(reg_addr(1), 32'h1111_2222, 4'hf, 0, 2, 0);
        read_txn(reg_addr(1), 0, 0);
        write_txn(reg_addr(1), 32'h3333_4444, 4'hf, 2, 0, 0);
        read_txn(reg_addr(1), 0, 0);
        write_txn(reg_addr(1), 32'h5555_6666, 4'hf, 0, 0, 0);
        read_txn(reg_addr(1), 0, 0);

        // Status registers, new values each round
        for (int r = 0; r < n_in_rounds; r++) begin
            for (int j = 0; j < n_read_regs; j++)
                in_regs[j] = data_t'($random(seed));
            for (int j = 0; j < n_read_regs; j++)
                read_random(reg_addr(n_write_regs + j));
            for (int j = 0; j < n_read_regs; j++)
                write_random(reg_addr(n_write_regs + j));
        end

        // Unmapped words in the window, then mapped offsets under a wrong base
        for (int n = 0; n < n_unmapped; n++) begin
            if (n % 2 == 0)
                addr = reg_addr(6 + int'(rand_below(1018)));
            else
                addr = (base_address ^ (addr_t'(1) << (window_bits + rand_below(20))))
                       + addr_t'(4 * rand_below(6));
            write_random(addr);
            read_random(addr);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/axil_register_top.sv
////////////////////////////////////////
// Register block top level
// Plain AXI-Lite ports onto the bundle
// Capture, control, bank and read mux
////////////////////////////////////////
`default_nettype none

module axil_register_top (
    input  wire logic                     clock,
    input  wire logic                     rst_n,
    input  wire axil_reg_pkg::addr_t      awaddr,
    input  wire logic [2:0]               awprot,
    input  wire logic                     awvalid,
    output logic                          awready,
    input  wire axil_reg_pkg::data_t      wdata,
    input  wire axil_reg_pkg::strb_t      wstrb,
    input  wire logic                     wvalid,
    output logic                          wready,
    output axil_reg_pkg::resp_t           bresp,
    output logic                          bvalid,
    input  wire logic                     bready,
    input  wire axil_reg_pkg::addr_t      araddr,
    input  wire logic [2:0]               arprot,
    input  wire logic                     arvalid,
    output logic                          arready,
    output axil_reg_pkg::data_t           rdata,
    output axil_reg_pkg::resp_t           rresp,
    output logic                          rvalid,
    input  wire logic                     rready,
    input  wire axil_reg_pkg::read_bank_t in_regs,
    output axil_reg_pkg::write_bank_t     out_regs
);
    import axil_reg_pkg::*;

    axi_lite_if bus ();

    // Capture to control unit
    logic     wr_pending;
    addr_t    wr_addr;
    data_t    wr_data;
    strb_t    wr_strb;
    logic     wr_consume;
    // Control unit to bank and mux
    logic     bank_we;
    reg_idx_t bank_idx;
    data_t    bank_data;
    strb_t    bank_strb;
    logic     rd_load;
    reg_idx_t rd_idx;
    data_t    rd_data;

    // Master side into the bundle
    assign bus.awaddr  = awaddr;
    assign bus.awprot  = awprot;
    assign bus.awvalid = awvalid;
    assign bus.wdata   = wdata;
    assign bus.wstrb   = wstrb;
    assign bus.wvalid  = wvalid;
    assign bus.bready  = bready;
    assign bus.araddr  = araddr;
    assign bus.arprot  = arprot;
    assign bus.arvalid = arvalid;
    assign bus.rready  = rready;

    // Slave side back out
    assign awready = bus.awready;
    assign wready  = bus.wready;
    assign bresp   = bus.bresp;
    assign bvalid  = bus.bvalid;
    assign arready = bus.arready;
    assign rdata   = bus.rdata;
    assign rresp   = bus.rresp;
    assign rvalid  = bus.rvalid;

    axil_write_capture axil_write_capture_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .wr_consume (wr_consume),
        .bus        (bus),
        .wr_pending (wr_pending),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_strb    (wr_strb)
    );

    axil_register_cu axil_register_cu_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .wr_pending (wr_pending),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_strb    (wr_strb),
        .rd_data    (rd_data),
        .bus        (bus),
        .wr_consume (wr_consume),
        .bank_we    (bank_we),
        .bank_data  (bank_data),
        .bank_strb  (bank_strb),
        .bank_idx   (bank_idx),
        .rd_load    (rd_load),
        .rd_idx     (rd_idx)
    );

    axil_register_bank axil_register_bank_inst (
        .clock     (clock),
        .rst_n     (rst_n),
        .bank_we   (bank_we),
        .bank_idx  (bank_idx),
        .bank_data (bank_data),
        .bank_strb (bank_strb),
        .regs      (out_regs)
    );

    // Read-back sees the live control registers
    axil_read_mux axil_read_mux_inst (
        .clock   (clock),
        .rst_n   (rst_n),
        .rd_load (rd_load),
        .rd_idx  (rd_idx),
        .wr_regs (out_regs),
        .in_regs (in_regs),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// File: rtl/axil_register_cu.sv
////////////////////////////////////////
// Register block control unit
// Address decode and classification
// Read and write sequencing FSM
// AR, B and R channel handshakes
// Response protocol assertions
////////////////////////////////////////
`default_nettype none

module axil_register_cu (
    input  wire logic                  clock,
    input  wire logic                  rst_n,
    input  wire logic                  wr_pending,
    input  wire axil_reg_pkg::addr_t   wr_addr,
    input  wire axil_reg_pkg::data_t   wr_data,
    input  wire axil_reg_pkg::strb_t   wr_strb,
    input  wire axil_reg_pkg::data_t   rd_data,
    axi_lite_if.slave                  bus,
    output logic                       wr_consume,
    output logic                       bank_we,
    output axil_reg_pkg::data_t        bank_data,
    output axil_reg_pkg::strb_t        bank_strb,
    output axil_reg_pkg::reg_idx_t     bank_idx,
    output logic                       rd_load,
    output axil_reg_pkg::reg_idx_t     rd_idx
);
    import axil_reg_pkg::*;

    // Word offset inside the window
    typedef logic [window_bits-3:0] word_t;

    localparam word_t first_rreg = word_t'(n_write_regs);
    localparam word_t end_rreg   = word_t'(n_write_regs + n_read_regs);

    cu_state_t state;
    cu_state_t state_next;
    // Keeps arready low through reset
    logic      ar_en;
    logic      ar_fire;
    addr_t     ar_addr_q;
    resp_t     bresp_q;
    resp_t     rresp_q;
    logic      rd_zero_q;
    word_t     wr_word;
    word_t     rd_word;
    logic      wr_in_win;
    logic      wr_is_wreg;
    logic      wr_is_rreg;
    logic      rd_mapped;

    // Upper bits must match the base
    function automatic logic in_window(addr_t a);
        return a[31:window_bits] == base_address[31:window_bits];
    endfunction

    // Write side decode, held address from the capture block
    assign wr_word    = wr_addr[window_bits-1:2];
    assign wr_in_win  = in_window(wr_addr);
    assign wr_is_wreg = wr_in_win && (wr_word < first_rreg);
    assign wr_is_rreg = wr_in_win && (wr_word >= first_rreg) && (wr_word < end_rreg);

    // Read side decode on the latched AR address
    assign rd_word   = ar_addr_q[window_bits-1:2];
    assign rd_mapped = in_window(ar_addr_q) && (rd_word < end_rreg);

    // Pending write blocks new reads
    assign bus.arready = ar_en && (state == idle) && !wr_pending;
    assign ar_fire     = bus.arvalid && bus.arready;

    // Response channels
    assign bus.bvalid = (state == write_resp);
    assign bus.bresp  = bresp_q;
    assign bus.rvalid = (state == read_resp);
    assign bus.rresp  = rresp_q;
    assign bus.rdata  = rd_zero_q ? '0 : rd_data;

    // One cycle strobes out of the exec states
    assign wr_consume = (state == write_exec);
    assign bank_we    = (state == write_exec) && wr_is_wreg;
    assign bank_idx   = reg_idx_t'(wr_word);
    assign bank_data  = wr_data;
    assign bank_strb  = wr_strb;
    assign rd_load    = (state == read_exec) && rd_mapped;
    assign rd_idx     = reg_idx_t'(rd_word);

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                // Writes win over reads
                if (wr_pending)
                    state_next = write_exec;
                else if (ar_fire)
                    state_next = read_exec;
            end
            write_exec: state_next = write_resp;
            write_resp: begin
                if (bus.bready)
                    state_next = idle;
            end
            read_exec: state_next = read_resp;
            read_resp: begin
                if (bus.rready)
                    state_next = idle;
            end
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= idle;
            ar_en <= 1'b0;
        end else begin
            state <= state_next;
            ar_en <= 1'b1;
        end
    end

    // Latched address and response payload
    always_ff @(posedge clock) begin
        if (ar_fire)
            ar_addr_q <= bus.araddr;
        if (state == write_exec) begin
            if (wr_is_wreg)
                bresp_q <= resp_okay;
            else if (wr_is_rreg)
                bresp_q <= resp_slverr;
            else
                bresp_q <= resp_decerr;
        end
        if (state == read_exec) begin
            rresp_q   <= rd_mapped ? resp_okay : resp_decerr;
            // Unmapped reads return zero
            rd_zero_q <= !rd_mapped;
        end
    end

    // Only one response channel active at a time
    one_response: assert property (
        @(posedge clock) disable iff (!rst_n)
        !(bus.bvalid && bus.rvalid)
    );

    b_hold: assert property (
        @(posedge clock) disable iff (!rst_n)
        (bus.bvalid && !bus.bready) |=> (bus.bvalid && $stable(bus.bresp))
    );

    // Data and response frozen across R back-pressure
    r_hold: assert property (
        @(posedge clock) disable iff (!rst_n)
        (bus.rvalid && !bus.rready) |=>
            (bus.rvalid && $stable(bus.rdata) && $stable(bus.rresp))
    );

endmodule

`default_nettype wire

// File: rtl/axil_read_mux.sv
////////////////////////////////////////
// Read data select
// Write bank below, input bank above
// Registered on load
////////////////////////////////////////
`default_nettype none

module axil_read_mux (
    input  wire logic                     clock,
    input  wire logic                     rst_n,
    input  wire logic                     rd_load,
    input  wire axil_reg_pkg::reg_idx_t   rd_idx,
    input  wire axil_reg_pkg::write_bank_t wr_regs,
    input  wire axil_reg_pkg::read_bank_t in_regs,
    output axil_reg_pkg::data_t           rd_data
);
    import axil_reg_pkg::*;

    data_t sel;

    // Word select by index
    always_comb begin
        sel = '0;
        for (int i = 0; i < n_write_regs; i++) begin
            if (rd_idx == reg_idx_t'(i))
                sel = wr_regs[i];
        end
        // Input registers sit right after the write bank
        for (int j = 0; j < n_read_regs; j++) begin
            if (rd_idx == reg_idx_t'(n_write_regs + j))
                sel = in_regs[j];
        end
    end

    // Held until the next load
    always_ff @(posedge clock) begin
        if (!rst_n)
            rd_data <= '0;
        else if (rd_load)
            rd_data <= sel;
    end

endmodule

`default_nettype wire

// File: rtl/axil_register_bank.sv
////////////////////////////////////////
// Control register bank
// Byte strobe merge on write enable
// Cleared to zero on reset
////////////////////////////////////////
`default_nettype none

module axil_register_bank (
    input  wire logic                  clock,
    input  wire logic                  rst_n,
    input  wire logic                  bank_we,
    input  wire axil_reg_pkg::reg_idx_t bank_idx,
    input  wire axil_reg_pkg::data_t   bank_data,
    input  wire axil_reg_pkg::strb_t   bank_strb,
    output axil_reg_pkg::write_bank_t  regs
);
    import axil_reg_pkg::*;

    // Per byte lane update
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (bank_we) begin
            for (int r = 0; r < n_write_regs; r++) begin
                // Index compare instead of a direct select
                if (bank_idx == reg_idx_t'(r)) begin
                    for (int b = 0; b < 4; b++) begin
                        if (bank_strb[b])
                            regs[r][8*b +: 8] <= bank_data[8*b +: 8];
                    end
                end
            end
        end
    end

    // Only write registers ever reach the bank
    idx_in_range: assert property (
        @(posedge clock) disable iff (!rst_n)
        bank_we |-> (int'(bank_idx) < n_write_regs)
    );

endmodule

`default_nettype wire

// File: rtl/axil_write_capture.sv
////////////////////////////////////////
// Write channel capture
// One address slot, one data slot
// AW and W accepted in any order
////////////////////////////////////////
`default_nettype none

module axil_write_capture (
    input  wire logic            clock,
    input  wire logic            rst_n,
    input  wire logic            wr_consume,
    axi_lite_if.slave            bus,
    output logic                 wr_pending,
    output axil_reg_pkg::addr_t  wr_addr,
    output axil_reg_pkg::data_t  wr_data,
    output axil_reg_pkg::strb_t  wr_strb
);
    import axil_reg_pkg::*;

    logic aw_full;
    logic w_full;
    // Low through reset, high from the first edge after it
    logic ready_en;
    logic aw_fire;
    logic w_fire;

    // Ready while the matching slot is empty
    assign bus.awready = ready_en && !aw_full;
    assign bus.wready  = ready_en && !w_full;

    assign aw_fire = bus.awvalid && bus.awready;
    assign w_fire  = bus.wvalid && bus.wready;

    // Both halves present
    assign wr_pending = aw_full && w_full;

    // Slot flags
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ready_en <= 1'b0;
            aw_full  <= 1'b0;
            w_full   <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            // Consume only comes with both slots full, so no fire can collide
            if (wr_consume) begin
                aw_full <= 1'b0;
                w_full  <= 1'b0;
            end
            if (aw_fire)
                aw_full <= 1'b1;
            if (w_fire)
                w_full <= 1'b1;
        end
    end

    // Held payload
    always_ff @(posedge clock) begin
        if (aw_fire)
            wr_addr <= bus.awaddr;
        if (w_fire) begin
            wr_data <= bus.wdata;
            wr_strb <= bus.wstrb;
        end
    end

    // Master keeps the address steady until it is taken
    awaddr_stable: assert property (
        @(posedge clock) disable iff (!rst_n)
        (bus.awvalid && !bus.awready) |=> $stable(bus.awaddr)
    );

endmodule

`default_nettype wire

// File: rtl/axi_lite_if.sv
////////////////////////////////////////
// AXI4-Lite bundle
// All five channels
// Slave and monitor modports
////////////////////////////////////////
`default_nettype none

interface axi_lite_if;
    import axil_reg_pkg::*;

    // Write address channel
    addr_t      awaddr;
    logic [2:0] awprot;
    logic       awvalid;
    logic       awready;

    // Write data channel
    data_t      wdata;
    strb_t      wstrb;
    logic       wvalid;
    logic       wready;

    // Write response channel
    resp_t      bresp;
    logic       bvalid;
    logic       bready;

    // Read address channel
    addr_t      araddr;
    logic [2:0] arprot;
    logic       arvalid;
    logic       arready;

    // Read data channel
    data_t      rdata;
    resp_t      rresp;
    logic       rvalid;
    logic       rready;

    // Register block side, each block drives only its own channels
    modport slave (
        input  awaddr, awprot, awvalid, output awready,
        input  wdata, wstrb, wvalid, output wready,
        output bresp, bvalid, input bready,
        input  araddr, arprot, arvalid, output arready,
        output rdata, rresp, rvalid, input rready
    );

    // Passive observer
    modport monitor (
        input awaddr, awprot, awvalid, awready,
        input wdata, wstrb, wvalid, wready,
        input bresp, bvalid, bready,
        input araddr, arprot, arvalid, arready,
        input rdata, rresp, rvalid, rready
    );

endinterface

`default_nettype wire

// File: rtl/axil_reg_pkg.sv
////////////////////////////////////////
// Register block shared definitions
// Address map constants and bank sizes
// Bus, response and bank typedefs
// Control unit state encoding
////////////////////////////////////////
`default_nettype none

package axil_reg_pkg;

    // Bus word types
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;

    // Window placement, 4 KiB above the base
    localparam addr_t base_address = 32'h4400_0000;
    localparam int    window_bits  = 12;

    // Bank sizes
    localparam int n_write_regs = 3;
    localparam int n_read_regs  = 3;

    // AXI response codes
    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_slverr = 2'b10;
    localparam resp_t resp_decerr = 2'b11;

    // Word index across both banks
    // 0..2 write registers, 3..5 input registers
    typedef logic [2:0] reg_idx_t;

    typedef data_t [n_write_regs-1:0] write_bank_t;
    typedef data_t [n_read_regs-1:0]  read_bank_t;

    // Control unit sequencing
    typedef enum logic [2:0] {
        idle,
        write_exec,
        write_resp,
        read_exec,
        read_resp
    } cu_state_t;

endpackage

`default_nettype wire
